//--- hw/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// width of addresses, data words and write masks
`define MEM_DATA_W 32
// memory depth in words, index taken from addr[9:2]
`define MEM_WORDS 256
// accepted read to rvalid, in cycles
`define MEM_READ_LAT 2
// cycles of mem_ready low after an accepted write
`define MEM_WRITE_BUSY 3

// data port command codes, anything else is a nop
`define MEM_CMD_NOP 3'd0
`define MEM_CMD_READ 3'd1
`define MEM_CMD_WRITE 3'd2

`endif

//--- hw/mem_pkg.sv
`default_nettype none

`include "mem_cfg.svh"

package mem_pkg;

	// one data word
	typedef logic [`MEM_DATA_W-1:0] word_t;
	// byte address, only bits 9..2 select a word
	typedef logic [`MEM_DATA_W-1:0] addr_t;
	// write mask, a set bit takes the new data bit
	typedef logic [`MEM_DATA_W-1:0] mask_t;
	// data port command code
	typedef logic [2:0] dcmd_t;

	// arbiter fsm
	typedef enum logic [1:0] {
		arb_idle,
		arb_issue,
		arb_wait_read
	} arb_state_t;

endpackage

`default_nettype wire

//--- hw/fetch_port.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_port (
	input  wire logic           clk,
	input  wire logic           arst_n,
	input  wire logic           inst_start,
	input  wire mem_pkg::addr_t i_addr,
	output logic                inst_ready,
	output mem_pkg::word_t      inst,
	output logic                inst_valid,
	output logic                fetch_req,
	output mem_pkg::addr_t      fetch_addr,
	input  wire logic           fetch_done,
	input  wire mem_pkg::word_t resp_data
);

	import mem_pkg::*;

	// registered ready and valid, gated by the strobe below
	logic ready_q;
	logic valid_q;
	word_t inst_q;

	// a strobe in the same cycle hides both flags
	assign inst_ready = ready_q & ~inst_start;
	assign inst_valid = valid_q & ~inst_start;
	assign inst = inst_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ready_q <= 1'b1;
			valid_q <= 1'b0;
			inst_q <= '0;
			fetch_req <= 1'b0;
		end else if (inst_start) begin
			// new fetch, stays pending until the arbiter serves it
			ready_q <= 1'b0;
			valid_q <= 1'b0;
			fetch_req <= 1'b1;
		end else if (fetch_done) begin
			// word is back, keep it and reopen the port
			ready_q <= 1'b1;
			valid_q <= 1'b1;
			inst_q <= resp_data;
			fetch_req <= 1'b0;
		end
	end

	// address held for the arbiter
	always_ff @(posedge clk) begin
		if (inst_start) begin
			fetch_addr <= i_addr;
		end
	end

endmodule

`default_nettype wire

//--- hw/data_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_cfg.svh"

module data_port (
	input  wire logic           clk,
	input  wire logic           arst_n,
	input  wire mem_pkg::dcmd_t d_cmd,
	input  wire mem_pkg::addr_t d_addr,
	input  wire mem_pkg::word_t wdata,
	input  wire mem_pkg::mask_t wmask,
	output logic                d_cmd_ready,
	output mem_pkg::word_t      rdata,
	output logic                rdata_valid,
	output logic                data_req,
	output logic                data_write,
	output mem_pkg::addr_t      data_addr,
	output mem_pkg::word_t      data_wdata,
	output mem_pkg::mask_t      data_wmask,
	input  wire logic           data_done,
	input  wire mem_pkg::word_t resp_data
);

	import mem_pkg::*;

	// command decode, unknown codes act as nop
	logic cmd_read;
	logic cmd_write;
	logic cmd_op;
	logic ready_q;
	logic valid_q;
	word_t rdata_q;

	assign cmd_read = (d_cmd == `MEM_CMD_READ);
	assign cmd_write = (d_cmd == `MEM_CMD_WRITE);
	assign cmd_op = cmd_read | cmd_write;

	// any live command hides ready and valid
	assign d_cmd_ready = ready_q & ~cmd_op;
	assign rdata_valid = valid_q & ~cmd_op;
	assign rdata = rdata_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ready_q <= 1'b1;
			valid_q <= 1'b0;
			rdata_q <= '0;
			data_req <= 1'b0;
			data_write <= 1'b0;
		end else if (cmd_op) begin
			// one pending command, old read data no longer valid
			ready_q <= 1'b0;
			valid_q <= 1'b0;
			data_req <= 1'b1;
			data_write <= cmd_write;
		end else if (data_done) begin
			ready_q <= 1'b1;
			data_req <= 1'b0;
			// writes leave rdata alone
			if (!data_write) begin
				valid_q <= 1'b1;
				rdata_q <= resp_data;
			end
		end
	end

	// operands of the pending command
	always_ff @(posedge clk) begin
		if (cmd_op) begin
			data_addr <= d_addr;
			data_wdata <= wdata;
			data_wmask <= wmask;
		end
	end

endmodule

`default_nettype wire

//--- hw/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
	input  wire logic           clk,
	input  wire logic           arst_n,
	input  wire logic           fetch_req,
	input  wire mem_pkg::addr_t fetch_addr,
	output logic                fetch_done,
	input  wire logic           data_req,
	input  wire logic           data_write,
	input  wire mem_pkg::addr_t data_addr,
	input  wire mem_pkg::word_t data_wdata,
	input  wire mem_pkg::mask_t data_wmask,
	output logic                data_done,
	output mem_pkg::word_t      resp_data,
	output logic                mem_start,
	output logic                mem_write,
	output mem_pkg::addr_t      mem_addr,
	output mem_pkg::word_t      mem_wdata,
	output mem_pkg::mask_t      mem_wmask,
	input  wire logic           mem_ready,
	input  wire mem_pkg::word_t mem_rdata,
	input  wire logic           mem_rvalid
);

	import mem_pkg::*;

	arb_state_t state;
	// set while the fetch port owns the memory
	logic grant_fetch;
	logic read_back;

	// command toward memory, only the data side ever writes
	assign mem_start = (state == arb_issue) & mem_ready;
	assign mem_write = ~grant_fetch & data_write;
	assign mem_addr = grant_fetch ? fetch_addr : data_addr;
	assign mem_wdata = data_wdata;
	assign mem_wmask = data_wmask;

	// returned word, the done pulses tell who takes it
	assign read_back = (state == arb_wait_read) & mem_rvalid;
	assign resp_data = mem_rdata;
	assign fetch_done = read_back & grant_fetch;
	// writes finish as soon as memory takes them
	assign data_done = (read_back & ~grant_fetch) | (mem_start & mem_write);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= arb_idle;
			grant_fetch <= 1'b0;
		end else begin
			case (state)
				arb_idle: begin
					// fetch first when both wait
					if (fetch_req || data_req) begin
						grant_fetch <= fetch_req;
						state <= arb_issue;
					end
				end
				arb_issue: begin
					if (mem_ready) begin
						if (mem_write) begin
							state <= arb_idle;
						end else begin
							state <= arb_wait_read;
						end
					end
				end
				arb_wait_read: begin
					// fixed latency, just wait for the pulse
					if (mem_rvalid) begin
						state <= arb_idle;
					end
				end
				default: begin
					state <= arb_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/word_memory.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_cfg.svh"

module word_memory (
	input  wire logic           clk,
	input  wire logic           arst_n,
	input  wire logic           mem_start,
	input  wire logic           mem_write,
	input  wire mem_pkg::addr_t mem_addr,
	input  wire mem_pkg::word_t mem_wdata,
	input  wire mem_pkg::mask_t mem_wmask,
	output logic                mem_ready,
	output mem_pkg::word_t      mem_rdata,
	output logic                mem_rvalid
);

	import mem_pkg::*;

	localparam int idx_w = $clog2(`MEM_WORDS);
	localparam int busy_w = $clog2(`MEM_WRITE_BUSY + 1);
	localparam int lat = `MEM_READ_LAT;

	word_t mem [`MEM_WORDS];
	logic [idx_w-1:0] idx;
	logic accept;
	logic [busy_w-1:0] busy_cnt;
	logic [lat-1:0] rd_valid;
	word_t rd_data [lat];

	// word index, upper bits wrap
	assign idx = mem_addr[idx_w+1:2];
	assign accept = mem_start & mem_ready;
	assign mem_ready = (busy_cnt == '0);
	assign mem_rvalid = rd_valid[lat-1];
	assign mem_rdata = rd_data[lat-1];

	// write busy counter and read valid shift
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_cnt <= '0;
			rd_valid <= '0;
		end else begin
			if (accept && mem_write) begin
				busy_cnt <= busy_w'(`MEM_WRITE_BUSY);
			end else if (busy_cnt != '0) begin
				busy_cnt <= busy_cnt - 1'b1;
			end
			rd_valid[0] <= accept & ~mem_write;
			for (int i = 1; i < lat; i++) begin
				rd_valid[i] <= rd_valid[i-1];
			end
		end
	end

	// array and read data pipe
	always_ff @(posedge clk) begin
		if (accept && mem_write) begin
			// masked merge of new and old bits
			mem[idx] <= (mem[idx] & ~mem_wmask) | (mem_wdata & mem_wmask);
		end
		rd_data[0] <= mem[idx];
		for (int i = 1; i < lat; i++) begin
			rd_data[i] <= rd_data[i-1];
		end
	end

endmodule

`default_nettype wire

//--- hw/mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys (
	input  wire logic           clk,
	input  wire logic           arst_n,
	input  wire logic           inst_start,
	output logic                inst_ready,
	input  wire mem_pkg::addr_t i_addr,
	output mem_pkg::word_t      inst,
	output logic                inst_valid,
	input  wire mem_pkg::dcmd_t d_cmd,
	output logic                d_cmd_ready,
	input  wire mem_pkg::addr_t d_addr,
	input  wire mem_pkg::word_t wdata,
	input  wire mem_pkg::mask_t wmask,
	output mem_pkg::word_t      rdata,
	output logic                rdata_valid
);

	import mem_pkg::*;

	// port to arbiter
	logic fetch_req;
	addr_t fetch_addr;
	logic fetch_done;
	logic data_req;
	logic data_write;
	addr_t data_addr;
	word_t data_wdata;
	mask_t data_wmask;
	logic data_done;
	word_t resp_data;
	// arbiter to memory
	logic mem_start;
	logic mem_write;
	addr_t mem_addr;
	word_t mem_wdata;
	mask_t mem_wmask;
	logic mem_ready;
	word_t mem_rdata;
	logic mem_rvalid;

	fetch_port u_fetch (.*);

	data_port u_data (.*);

	// fixed priority, fetch wins
	mem_arbiter u_arb (.*);

	word_memory u_mem (.*);

endmodule

`default_nettype wire

//--- verif/tb_mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_cfg.svh"

module tb_mem_subsys;

	import mem_pkg::*;

	localparam int idx_w = $clog2(`MEM_WORDS);
	localparam int rand_cycles = 400;
	// fill, one directed pair, at most two ops per random cycle
	localparam int max_ops = `MEM_WORDS + 2 + 2 * rand_cycles;
	localparam int timeout_cycles = 20 * max_ops;

	logic clk;
	logic arst_n;
	logic inst_start;
	logic inst_ready;
	addr_t i_addr;
	word_t inst;
	logic inst_valid;
	dcmd_t d_cmd;
	logic d_cmd_ready;
	addr_t d_addr;
	word_t wdata;
	mask_t wmask;
	word_t rdata;
	logic rdata_valid;

	// reference memory and outstanding requests
	word_t model [`MEM_WORDS];
	logic fetch_busy;
	word_t fetch_exp;
	logic data_busy;
	logic data_read;
	word_t data_exp;
	logic [31:0] lfsr;
	int cycles;

	mem_subsys dut (
		.clk(clk),
		.arst_n(arst_n),
		.inst_start(inst_start),
		.inst_ready(inst_ready),
		.i_addr(i_addr),
		.inst(inst),
		.inst_valid(inst_valid),
		.d_cmd(d_cmd),
		.d_cmd_ready(d_cmd_ready),
		.d_addr(d_addr),
		.wdata(wdata),
		.wmask(wmask),
		.rdata(rdata),
		.rdata_valid(rdata_valid)
	);

	always #5 clk = ~clk;

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	// runaway guard
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout: requests still open after %0d cycles", cycles);
			abort_run();
		end
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// crowd random traffic onto 16 words, upper and low bits stay random
	function automatic addr_t hot_addr(input logic [31:0] a);
		return {a[31:10], 4'b0000, a[5:0]};
	endfunction

	// ready back high means the request was served
	task automatic check_done();
		if (fetch_busy && inst_ready) begin
			assert (inst_valid === 1'b1 && inst === fetch_exp) else begin
				$display("ERROR %0t fetch: inst_valid %b inst %h expected %h",
					$time, inst_valid, inst, fetch_exp);
				abort_run();
			end
			fetch_busy = 1'b0;
		end
		if (data_busy && d_cmd_ready) begin
			// a write leaves rdata_valid low and rdata untouched
			assert (rdata_valid === data_read && rdata === data_exp) else begin
				$display("ERROR %0t data %s: rdata_valid %b rdata %h expected %h",
					$time, data_read ? "read" : "write", rdata_valid, rdata, data_exp);
				abort_run();
			end
			data_busy = 1'b0;
		end
		if (!data_busy) begin
			// idle port, an unknown code must not take it
			assert (d_cmd_ready === 1'b1) else begin
				$display("ERROR %0t idle data port: d_cmd %h d_cmd_ready %b",
					$time, d_cmd, d_cmd_ready);
				abort_run();
			end
		end
	endtask

	// one edge, strobes drop unless reissued
	task automatic step();
		@(posedge clk);
		inst_start <= 1'b0;
		d_cmd <= `MEM_CMD_NOP;
		check_done();
	endtask

	task automatic issue_fetch(input addr_t a);
		inst_start <= 1'b1;
		i_addr <= a;
		fetch_exp = model[a[idx_w+1:2]];
		fetch_busy = 1'b1;
	endtask

	task automatic issue_data(input dcmd_t cmd, input addr_t a, input word_t d, input mask_t m);
		logic [idx_w-1:0] w;
		w = a[idx_w+1:2];
		d_cmd <= cmd;
		d_addr <= a;
		wdata <= d;
		wmask <= m;
		// model moves when the write is accepted
		if (cmd == `MEM_CMD_WRITE) begin
			// each set mask bit takes the new data bit
			for (int b = 0; b < `MEM_DATA_W; b++) begin
				if (m[b]) begin
					model[w][b] = d[b];
				end
			end
		end else begin
			data_exp = model[w];
		end
		data_read = (cmd == `MEM_CMD_READ);
		data_busy = 1'b1;
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] m;
		clk = 1'b0;
		arst_n = 1'b0;
		inst_start = 1'b0;
		i_addr = '0;
		d_cmd = `MEM_CMD_NOP;
		d_addr = '0;
		wdata = '0;
		wmask = '0;
		fetch_busy = 1'b0;
		fetch_exp = '0;
		data_busy = 1'b0;
		data_read = 1'b0;
		data_exp = '0;
		lfsr = 32'hc88fb778;
		cycles = 0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		assert (inst_ready === 1'b1 && d_cmd_ready === 1'b1 &&
			inst_valid === 1'b0 && rdata_valid === 1'b0) else begin
			$display("ERROR %0t reset: inst_ready %b d_cmd_ready %b inst_valid %b rdata_valid %b",
				$time, inst_ready, d_cmd_ready, inst_valid, rdata_valid);
			abort_run();
		end

		// fill every word with full masks
		for (int i = 0; i < `MEM_WORDS; i++) begin
			do step(); while (data_busy);
			take_bits(32, d);
			issue_data(`MEM_CMD_WRITE, addr_t'(i) << 2, d, '1);
		end

		// fetch and read of one word through two aliases, same cycle
		do step(); while (fetch_busy || data_busy);
		take_bits(32, a);
		issue_fetch(a);
		issue_data(`MEM_CMD_READ, {~a[31:10], a[9:2], ~a[1:0]}, '0, '0);
		do step(); while (fetch_busy || data_busy);

		for (int c = 0; c < rand_cycles; c++) begin
			step();
			// fetch first so a same-cycle write is not seen by it
			if (!fetch_busy) begin
				take_bits(1, r);
				if (r[0]) begin
					take_bits(32, a);
					issue_fetch(hot_addr(a));
				end
			end
			if (!data_busy) begin
				take_bits(2, r);
				take_bits(32, a);
				take_bits(32, d);
				take_bits(32, m);
				if (r[1:0] == 2'd1) begin
					issue_data(`MEM_CMD_READ, hot_addr(a), d, m);
				end else if (r[1:0] == 2'd2) begin
					issue_data(`MEM_CMD_WRITE, hot_addr(a), d, m);
				end else if (r[1:0] == 2'd3) begin
					// unknown code, must act as nop
					d_cmd <= 3'd7;
				end
			end
		end

		while (fetch_busy || data_busy) begin
			step();
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/mem_pkg.sv
hw/fetch_port.sv
hw/data_port.sv
hw/mem_arbiter.sv
hw/word_memory.sv
hw/mem_subsys.sv
verif/tb_mem_subsys.sv
